//--- files.f
+incdir+hw
hw/video_fx_pkg.sv
hw/effect_sequencer.sv
hw/pixel_counter.sv
hw/window_3x3.sv
hw/pixel_effects.sv
hw/video_fx_top.sv
tb/video_fx_tb.sv

//--- hw/effect_sequencer.sv
// Effect selector
// Steps to the next effect on each button press and commits it
// only during vertical sync so a frame never mixes two effects
`timescale 1ns/100ps

module effect_sequencer
  import video_fx_pkg::*;
(
  input  logic    VGA_CLK,
  input  logic    rst,
  input  logic    button,  // Active high level
  input  logic    vs,      // Active low
  output effect_t effect
);

  typedef enum logic {
    IDLE,     // Nothing waiting
    PENDING   // New effect waits for vs
  } seq_state_t;

  seq_state_t state;
  effect_t    pending;    // Effect to commit at next vs
  effect_t    pend_next;  // One step past the newest choice
  logic       button_d;   // Last button level
  logic       press;      // Rising edge of button

  assign press = button && !button_d;

  // While pending, further presses step from the pending choice
  assign pend_next = effect_t'(((state == PENDING) ? pending : effect) + 2'd1);

  ////////////////////////////////////////////////////////////
  // Press tracking and commit
  ////////////////////////////////////////////////////////////

  always_ff @(posedge VGA_CLK)
  begin
    if (rst)
    begin
      state    <= IDLE;
      effect   <= FX_PASS;
      pending  <= FX_PASS;
      button_d <= 1'b0;
    end
    else
    begin
      button_d <= button;
      case (state)
        IDLE:
        begin
          if (press)
          begin
            pending <= pend_next;
            state   <= PENDING;
          end
        end
        PENDING:
        begin
          if (!vs)
          begin
            effect <= press ? pend_next : pending;  // Late press still counts
            state  <= IDLE;
          end
          else if (press)
            pending <= pend_next;                   // Another step, same frame
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Effect may only move on a clock where vs was low
  a_commit_in_vs: assert property (@(posedge VGA_CLK) disable iff (rst)
    !$stable(effect) |-> !$past(vs));

endmodule

//--- hw/pixel_counter.sv
// Active area position counters
// Column counts visible pixels and stops at the line length,
// row counts lines since the last vertical sync
`timescale 1ns/100ps
`include "video_fx_config.svh"

module pixel_counter
  import video_fx_pkg::*;
(
  input  logic VGA_CLK,
  input  logic rst,
  input  logic active,   // High on visible pixels
  input  logic vs,       // Active low
  output col_t col,      // Index of the pixel now on the input
  output row_t row,
  output logic in_line   // Pixel goes to the line buffers
);

  logic active_d;   // Last active level
  logic line_end;   // Falling edge of active

  assign line_end = active_d && !active;

  // Counter parks at the line length, later pixels are dropped
  assign in_line = active && (col != col_t'(`FX_LINE_PIXELS));

  always_ff @(posedge VGA_CLK)
  begin
    if (rst)
    begin
      col      <= '0;
      row      <= '0;
      active_d <= 1'b0;
    end
    else
    begin
      active_d <= active;
      if (!active)
        col <= '0;                // Back to start in blanking
      else if (in_line)
        col <= col + col_t'(1);
      if (!vs)
        row <= '0;                // New frame
      else if (line_end)
        row <= row + row_t'(1);
    end
  end

  // Parking must hold col in range for every buffered pixel
  a_col_in_range: assert property (@(posedge VGA_CLK) disable iff (rst)
    in_line |-> (col < `FX_LINE_PIXELS));

endmodule

//--- hw/pixel_effects.sv
// Effect kernels and output stage
// Pass, invert, channel rotate and thresholded Sobel on green,
// one picked by effect and registered with the sync levels
`timescale 1ns/100ps
`include "video_fx_config.svh"

module pixel_effects
  import video_fx_pkg::*;
(
  input  logic    VGA_CLK,
  input  logic    rst,
  input  pixel_t  w00,
  input  pixel_t  w01,
  input  pixel_t  w02,
  input  pixel_t  w10,
  input  pixel_t  w11,
  input  pixel_t  w12,
  input  pixel_t  w20,
  input  pixel_t  w21,
  input  pixel_t  w22,
  input  logic    win_active,
  input  logic    win_hs,
  input  logic    win_vs,
  input  effect_t effect,
  output pixel_t  pix_out,
  output logic    out_active,
  output logic    out_hs,
  output logic    out_vs
);

  localparam int CB = `FX_CHAN_BITS;
  localparam int SUM_BITS = CB + 4;   // 4x channel plus sign

  typedef logic signed [SUM_BITS-1:0] sum_t;

  channel_t red;       // Centre channels
  channel_t green;
  channel_t blue;
  sum_t     gx;        // Right column minus left
  sum_t     gy;        // Bottom line minus top
  sum_t     abs_gx;
  sum_t     abs_gy;
  sum_t     mag;
  logic     edge_hit;
  pixel_t   fx_pix;    // Selected effect result

  // Green channel, zero extended into the Sobel sum width
  function automatic sum_t green_w(input pixel_t p);
    return sum_t'({4'b0000, p[2*CB-1:CB]});
  endfunction

  assign red   = w11[3*CB-1:2*CB];
  assign green = w11[2*CB-1:CB];
  assign blue  = w11[CB-1:0];

  ////////////////////////////////////////////////////////////
  // Sobel on green
  ////////////////////////////////////////////////////////////

  assign gx = (green_w(w02) + (green_w(w12) <<< 1) + green_w(w22))
            - (green_w(w00) + (green_w(w10) <<< 1) + green_w(w20));
  assign gy = (green_w(w20) + (green_w(w21) <<< 1) + green_w(w22))
            - (green_w(w00) + (green_w(w01) <<< 1) + green_w(w02));

  assign abs_gx = gx[SUM_BITS-1] ? -gx : gx;
  assign abs_gy = gy[SUM_BITS-1] ? -gy : gy;
  assign mag    = abs_gx + abs_gy;  // L1 magnitude, fits without sign

  assign edge_hit = (mag > sum_t'(`FX_EDGE_THRESHOLD));

  // Effect select
  always_comb
  begin
    case (effect)
      FX_PASS:   fx_pix = w11;
      FX_INVERT: fx_pix = ~w11;
      FX_ROTATE: fx_pix = {green, blue, red};
      FX_EDGE:   fx_pix = edge_hit ? '1 : '0;   // White edge, black elsewhere
      default:   fx_pix = w11;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Output register, stage 3
  ////////////////////////////////////////////////////////////

  always_ff @(posedge VGA_CLK)
  begin
    if (rst)
    begin
      pix_out    <= '0;
      out_active <= 1'b0;
      out_hs     <= 1'b1;
      out_vs     <= 1'b1;
    end
    else
    begin
      pix_out    <= win_active ? fx_pix : '0;   // Black in blanking
      out_active <= win_active;
      out_hs     <= win_hs;
      out_vs     <= win_vs;
    end
  end

endmodule

//--- hw/video_fx_config.svh
// Video effect stage configuration
// Stream geometry, channel and counter widths, edge threshold and latency
`ifndef VIDEO_FX_CONFIG_SVH
`define VIDEO_FX_CONFIG_SVH

////////////////////////////////////////////////////////////
// Stream geometry
////////////////////////////////////////////////////////////

`define FX_LINE_PIXELS 640     // Visible pixels buffered per line

////////////////////////////////////////////////////////////
// Word widths
////////////////////////////////////////////////////////////

`define FX_CHAN_BITS 10        // One of red, green, blue
`define FX_COL_BITS 10         // Column index, must reach FX_LINE_PIXELS
`define FX_ROW_BITS 10         // Row index within a frame

////////////////////////////////////////////////////////////
// Effect tuning and pipeline depth
////////////////////////////////////////////////////////////

// Sobel magnitude above this draws a white pixel
`define FX_EDGE_THRESHOLD 10'd256

// Input edge to output edge, counters, window, effect register
`define FX_LATENCY 3

`endif

//--- hw/video_fx_pkg.sv
// Shared types for the video effect stage
// Channel and pixel words, position indices and the effect selector
`include "video_fx_config.svh"

package video_fx_pkg;

  // One colour channel
  typedef logic [`FX_CHAN_BITS-1:0] channel_t;

  // Full pixel, red in the top bits, then green, then blue
  typedef logic [3*`FX_CHAN_BITS-1:0] pixel_t;

  // Position within the active area
  typedef logic [`FX_COL_BITS-1:0] col_t;
  typedef logic [`FX_ROW_BITS-1:0] row_t;

  // Effect order is also the button stepping order
  typedef enum logic [1:0] {
    FX_PASS   = 2'd0,  // Centre pixel as is
    FX_INVERT = 2'd1,  // All channels complemented
    FX_ROTATE = 2'd2,  // R <- G, G <- B, B <- R
    FX_EDGE   = 2'd3   // Thresholded Sobel on green
  } effect_t;

endpackage

//--- hw/video_fx_top.sv
// Video effect stage top level
// Pixel stream in, one selected 3x3 effect out, three clocks later
`timescale 1ns/100ps

module video_fx_top
  import video_fx_pkg::*;
(
  input  logic   VGA_CLK,
  input  logic   rst,
  input  pixel_t pix_in,
  input  logic   active,      // High on visible pixels
  input  logic   hs,          // Active low
  input  logic   vs,          // Active low
  input  logic   button,      // Effect step
  output pixel_t pix_out,
  output logic   out_active,
  output logic   out_hs,
  output logic   out_vs
);

  col_t    col;
  row_t    row;
  logic    in_line;
  effect_t effect;
  pixel_t  w00;
  pixel_t  w01;
  pixel_t  w02;
  pixel_t  w10;
  pixel_t  w11;
  pixel_t  w12;
  pixel_t  w20;
  pixel_t  w21;
  pixel_t  w22;
  logic    win_active;
  logic    win_hs;
  logic    win_vs;

  // Button to committed effect
  effect_sequencer u_seq (
    .VGA_CLK (VGA_CLK),
    .rst     (rst),
    .button  (button),
    .vs      (vs),
    .effect  (effect)
  );

  // Position of the incoming pixel
  pixel_counter u_cnt (
    .VGA_CLK (VGA_CLK),
    .rst     (rst),
    .active  (active),
    .vs      (vs),
    .col     (col),
    .row     (row),
    .in_line (in_line)
  );

  window_3x3 u_win (
    .VGA_CLK    (VGA_CLK),    .rst    (rst),
    .pix_in     (pix_in),     .active (active),
    .hs         (hs),         .vs     (vs),
    .col        (col),        .row    (row),
    .in_line    (in_line),
    .w00 (w00), .w01 (w01), .w02 (w02),
    .w10 (w10), .w11 (w11), .w12 (w12),
    .w20 (w20), .w21 (w21), .w22 (w22),
    .win_active (win_active), .win_hs (win_hs), .win_vs (win_vs)
  );

  pixel_effects u_fx (
    .VGA_CLK    (VGA_CLK),    .rst    (rst),
    .w00 (w00), .w01 (w01), .w02 (w02),
    .w10 (w10), .w11 (w11), .w12 (w12),
    .w20 (w20), .w21 (w21), .w22 (w22),
    .win_active (win_active), .win_hs (win_hs), .win_vs (win_vs),
    .effect     (effect),
    .pix_out    (pix_out),    .out_active (out_active),
    .out_hs     (out_hs),     .out_vs     (out_vs)
  );

endmodule

//--- hw/window_3x3.sv
// 3x3 neighbourhood builder
// Two cascaded line buffers feed a register window, with zero taps
// above row 0 and before column 0, and sync levels kept in step
`timescale 1ns/100ps
`include "video_fx_config.svh"

module window_3x3
  import video_fx_pkg::*;
(
  input  logic   VGA_CLK,
  input  logic   rst,
  input  pixel_t pix_in,
  input  logic   active,
  input  logic   hs,
  input  logic   vs,
  input  col_t   col,
  input  row_t   row,
  input  logic   in_line,
  output pixel_t w00,         // Oldest line, oldest column
  output pixel_t w01,
  output pixel_t w02,
  output pixel_t w10,
  output pixel_t w11,         // Centre
  output pixel_t w12,
  output pixel_t w20,
  output pixel_t w21,
  output pixel_t w22,         // Newest line, newest column
  output logic   win_active,
  output logic   win_hs,
  output logic   win_vs
);

  pixel_t line_a [`FX_LINE_PIXELS];  // Previous line
  pixel_t line_b [`FX_LINE_PIXELS];  // Line before that
  pixel_t new_pix;                   // Stage 1, current line
  pixel_t up_pix;                    // Stage 1, one line up
  pixel_t up2_pix;                   // Stage 1, two lines up
  pixel_t row_in [3];                // Feed per window row, oldest first
  pixel_t win [3][3];                // [line][column], column 2 newest
  logic   s_active;
  logic   s_hs;
  logic   s_vs;
  logic   lb_we;                     // Line buffer write

  assign lb_we = in_line;

  ////////////////////////////////////////////////////////////
  // Line buffers, stage 1
  ////////////////////////////////////////////////////////////

  // Read before write, so line_b takes the old line_a entry
  always_ff @(posedge VGA_CLK)
  begin
    if (lb_we)
    begin
      line_b[col] <= line_a[col];
      line_a[col] <= pix_in;
    end
  end

  always_ff @(posedge VGA_CLK)
  begin
    new_pix <= pix_in;
    up_pix  <= (in_line && row != '0) ? line_a[col] : '0;         // Zero above row 0
    up2_pix <= (in_line && row > row_t'(1)) ? line_b[col] : '0;
  end

  assign row_in[0] = up2_pix;
  assign row_in[1] = up_pix;
  assign row_in[2] = new_pix;

  ////////////////////////////////////////////////////////////
  // Window shift, stage 2
  ////////////////////////////////////////////////////////////

  always_ff @(posedge VGA_CLK)
  begin
    for (int r = 0; r < 3; r++)
    begin
      if (s_active)
      begin
        win[r][0] <= win[r][1];
        win[r][1] <= win[r][2];
        win[r][2] <= row_in[r];
      end
      else
      begin
        win[r][0] <= '0;          // Blank gives the left padding
        win[r][1] <= '0;
        win[r][2] <= '0;
      end
    end
  end

  assign w00 = win[0][0];
  assign w01 = win[0][1];
  assign w02 = win[0][2];
  assign w10 = win[1][0];
  assign w11 = win[1][1];
  assign w12 = win[1][2];
  assign w20 = win[2][0];
  assign w21 = win[2][1];
  assign w22 = win[2][2];

  // Sync levels, two stages to match the window
  always_ff @(posedge VGA_CLK)
  begin
    if (rst)
    begin
      s_active   <= 1'b0;
      s_hs       <= 1'b1;
      s_vs       <= 1'b1;
      win_active <= 1'b0;
      win_hs     <= 1'b1;
      win_vs     <= 1'b1;
    end
    else
    begin
      s_active   <= active;
      s_hs       <= hs;
      s_vs       <= vs;
      win_active <= s_active;
      win_hs     <= s_hs;
      win_vs     <= s_vs;
    end
  end

  // Writes only on visible pixels inside the buffered length
  a_write_in_line: assert property (@(posedge VGA_CLK) disable iff (rst)
    lb_we |-> (active && col < `FX_LINE_PIXELS));

endmodule

//--- tb/video_fx_tb.sv
// Video effect stage testbench
// Streams random and bar frames through the DUT, steps the effect with
// button presses and checks every output against a reference model
`timescale 1ns/100ps
`include "video_fx_config.svh"

module video_fx_tb
  import video_fx_pkg::*;
();

  localparam int CB           = `FX_CHAN_BITS;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 3;
  localparam int LEAD_IDLE    = 5;    // Blank cycles before the first frame
  localparam int VS_CYCLES    = 10;
  localparam int FRAME_ROWS   = 6;
  localparam int BLANK_CYCLES = 20;   // Horizontal blanking per line
  localparam int LINE_CYCLES  = `FX_LINE_PIXELS + BLANK_CYCLES;
  localparam int FRAME_CYCLES = VS_CYCLES + FRAME_ROWS * LINE_CYCLES;
  localparam int N_FRAMES     = 7;
  localparam int TAIL_IDLE    = 8;
  localparam int TOTAL_CYCLES = RESET_CYCLES + LEAD_IDLE
                              + N_FRAMES * FRAME_CYCLES + TAIL_IDLE;
  localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_PERIOD * 3 / 2;
  localparam int BAR_FIRST    = 300;  // Bright vertical bar in the edge frame
  localparam int BAR_WIDTH    = 10;

  logic    VGA_CLK;
  logic    rst;
  pixel_t  pix_in;
  logic    active;
  logic    hs;
  logic    vs;
  logic    button;
  pixel_t  pix_out;
  logic    out_active;
  logic    out_hs;
  logic    out_vs;

  integer  seed;
  pixel_t  img [FRAME_ROWS][`FX_LINE_PIXELS];  // Current frame as sent
  effect_t frame_fx;                           // Effect expected this frame
  int      pend_presses;                       // Presses not yet committed
  int      edge_hits;
  int      edge_misses;
  int      checked;                            // Expected entries compared
  pixel_t  exp_pix [$];                        // One entry per driven cycle
  logic    exp_act [$];
  logic    exp_hs [$];
  logic    exp_vs [$];

  initial VGA_CLK = 1'b0;
  always #(CLK_PERIOD / 2) VGA_CLK = ~VGA_CLK;

  video_fx_top UUT (
    .VGA_CLK    (VGA_CLK),
    .rst        (rst),
    .pix_in     (pix_in),
    .active     (active),
    .hs         (hs),
    .vs         (vs),
    .button     (button),
    .pix_out    (pix_out),
    .out_active (out_active),
    .out_hs     (out_hs),
    .out_vs     (out_vs)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Zero outside the frame, above row 0 and left of column 0
  function automatic pixel_t frame_pixel(input int r, input int c);
    if (r < 0 || c < 0)
      return '0;
    return img[r][c];
  endfunction

  function automatic int green_of(input pixel_t p);
    return int'(p[2*CB-1:CB]);
  endfunction

  // Output for input position (r, c), window centred one up and one left
  function automatic pixel_t expected_pixel(input effect_t fx, input int r, input int c);
    pixel_t   ctr;
    channel_t red;
    channel_t green;
    channel_t blue;
    int       g [3][3];   // Green taps, [line][column]
    int       gx;
    int       gy;
    int       mag;
    ctr   = frame_pixel(r - 1, c - 1);
    red   = ctr[3*CB-1:2*CB];
    green = ctr[2*CB-1:CB];
    blue  = ctr[CB-1:0];
    for (int i = 0; i < 3; i++)
      for (int j = 0; j < 3; j++)
        g[i][j] = green_of(frame_pixel(r - 2 + i, c - 2 + j));
    gx  = (g[0][2] + 2 * g[1][2] + g[2][2]) - (g[0][0] + 2 * g[1][0] + g[2][0]);
    gy  = (g[2][0] + 2 * g[2][1] + g[2][2]) - (g[0][0] + 2 * g[0][1] + g[0][2]);
    mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
    case (fx)
      FX_PASS:   return ctr;
      FX_INVERT: return ~ctr;
      FX_ROTATE: return {green, blue, red};     // R from G, G from B, B from R
      default:   return (mag > `FX_EDGE_THRESHOLD) ? {(3*CB){1'b1}} : pixel_t'(0);
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic fail_now();
    $display("Test FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic match_pixel(input pixel_t got, input pixel_t want, input int idx);
    if (got !== want)
    begin
      $display("[ERROR] %0d ns: pix_out is %h, expected %h for input cycle %0d",
               $time, got, want, idx);
      fail_now();
    end
  endtask

  task automatic check_active(input logic got, input logic want, input int idx);
    if (got !== want)
    begin
      $display("[ERROR] %0d ns: out_active is %b, expected %b for input cycle %0d",
               $time, got, want, idx);
      fail_now();
    end
  endtask

  task automatic verify_sync(input logic got, input logic want, input string name,
                             input int idx);
    if (got !== want)
    begin
      $display("[ERROR] %0d ns: %s is %b, expected %b for input cycle %0d",
               $time, name, got, want, idx);
      fail_now();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // One input cycle on the falling edge, expected output queued with it
  task automatic drive_cycle(input pixel_t p, input logic act, input logic h,
                             input logic v, input logic btn, input pixel_t want);
    @(negedge VGA_CLK);
    pix_in = p;
    active = act;
    hs     = h;
    vs     = v;
    button = btn;
    exp_pix.push_back(act ? want : pixel_t'(0));  // Black in blanking
    exp_act.push_back(act);
    exp_hs.push_back(h);
    exp_vs.push_back(v);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
      drive_cycle(pixel_t'($random(seed)), 1'b0, 1'b1, 1'b1, 1'b0, '0);  // Junk pixel
  endtask

  // Vs pulse, then the rows; presses go out on row 2
  task automatic send_frame(input bit bar, input int presses);
    pixel_t p;
    pixel_t e;
    logic   btn;
    logic   h;
    frame_fx     = effect_t'((int'(frame_fx) + pend_presses) % 4);  // Taken at this vs
    pend_presses = 0;
    repeat (VS_CYCLES)
      drive_cycle(pixel_t'($random(seed)), 1'b0, 1'b1, 1'b0, 1'b0, '0);
    for (int r = 0; r < FRAME_ROWS; r++)
    begin
      for (int c = 0; c < `FX_LINE_PIXELS; c++)
      begin
        p = pixel_t'($random(seed));
        if (bar)
        begin
          if (c >= BAR_FIRST && c < BAR_FIRST + BAR_WIDTH)
            p[2*CB-1:CB] = '1;                                 // Bright green bar
          else
            p[2*CB-1:CB] = p[2*CB-1:CB] & channel_t'(31);      // Noise stays under threshold
        end
        img[r][c] = p;
        e = expected_pixel(frame_fx, r, c);
        if (frame_fx == FX_EDGE)
        begin
          if (e == '0)
            edge_misses++;
          else
            edge_hits++;
        end
        // Each press high for 8 pixels, 64 apart
        btn = (r == 2) && (c / 64 >= 1) && (c / 64 <= presses) && (c % 64 < 8);
        drive_cycle(p, 1'b1, 1'b1, 1'b1, btn, e);
      end
      for (int b = 0; b < BLANK_CYCLES; b++)
      begin
        h = !(b >= 4 && b < 12);   // Hs pulse inside blanking
        drive_cycle(pixel_t'($random(seed)), 1'b0, h, 1'b1, 1'b0, '0);
      end
    end
    pend_presses = pend_presses + presses;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst          = 1'b1;
    pix_in       = '0;
    active       = 1'b0;
    hs           = 1'b1;
    vs           = 1'b1;
    button       = 1'b0;
    seed         = 32'h1f81f27d;
    frame_fx     = FX_PASS;
    pend_presses = 0;
    edge_hits    = 0;
    edge_misses  = 0;
    checked      = 0;
    idle_cycles(RESET_CYCLES);
    rst = 1'b0;
    idle_cycles(LEAD_IDLE);
    send_frame(1'b0, 0);   // Pass
    send_frame(1'b0, 1);   // Still pass, press waits for vs
    send_frame(1'b0, 1);   // Invert
    send_frame(1'b0, 1);   // Rotate
    send_frame(1'b1, 1);   // Edge on the bar image
    send_frame(1'b0, 2);   // Wrapped to pass, two presses
    send_frame(1'b0, 0);   // Rotate after double step
    idle_cycles(TAIL_IDLE);
    wait (checked == exp_pix.size());
    if (edge_hits > 0 && edge_misses > 0)
    begin
      $display("Test OK");
      $finish;
    end
    else
    begin
      $display("Edge frame did not give both white and black pixels");
      fail_now();
    end
  end

  // Outputs settle at the rising edge, read at the falling edge
  initial
  begin : compare_outputs
    int n;
    int idx;
    n = 0;
    forever
    begin
      @(negedge VGA_CLK);
      if (n < `FX_LATENCY)
      begin
        match_pixel(pix_out, '0, n);             // Reset values
        check_active(out_active, 1'b0, n);
        verify_sync(out_hs, 1'b1, "out_hs", n);
        verify_sync(out_vs, 1'b1, "out_vs", n);
      end
      else if (n - `FX_LATENCY < exp_pix.size())
      begin
        idx = n - `FX_LATENCY;                   // Input driven 3 cycles ago
        match_pixel(pix_out, exp_pix[idx], idx);
        check_active(out_active, exp_act[idx], idx);
        verify_sync(out_hs, exp_hs[idx], "out_hs", idx);
        verify_sync(out_vs, exp_vs[idx], "out_vs", idx);
        checked++;
      end
      n++;
    end
  end

  // Run length bound, half again the stimulus time
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: outputs were not all checked within %0d ns", WATCHDOG_NS);
    fail_now();
  end

endmodule
